//--- id2_stage.f
design/id2_pkg.sv
design/inst_classifier.sv
design/ctrl_decoder.sv
design/operand_fetch.sv
design/id2_stage.sv
sim/tb_clock_gen.sv
sim/id2_stage_props.sv
sim/id2_stage_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = id2_stage_tb
FILELIST   = id2_stage.f
OBJ_DIR    = obj_dir
PASS_MSG   = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/id2_stage_tb.sv
`timescale 1ns/1ps

module id2_stage_tb;

    localparam int n_tests = 2000;
    localparam int n_kept  = 54;

    // kept encodings, listed in inst_op_e order from OP_ADD up
    localparam logic [31:0] kept_enc [n_kept] = '{
        32'h0000_0020, 32'h0000_0021, 32'h0000_0022, 32'h0000_0023, 32'h0000_002a,
        32'h0000_002b, 32'h0000_0024, 32'h0000_0025, 32'h0000_0026, 32'h0000_0027,
        32'h0000_0000, 32'h0000_0002, 32'h0000_0003, 32'h0000_0004, 32'h0000_0006,
        32'h0000_0007, 32'h0000_0018, 32'h0000_0019, 32'h0000_001a, 32'h0000_001b,
        32'h0000_0010, 32'h0000_0012, 32'h0000_0011, 32'h0000_0013, 32'h0000_0008,
        32'h0000_0009, 32'h0000_000c, 32'h0000_000d, 32'h2000_0000, 32'h2400_0000,
        32'h2800_0000, 32'h2c00_0000, 32'h3000_0000, 32'h3400_0000, 32'h3800_0000,
        32'h3c00_0000, 32'h8000_0000, 32'h9000_0000, 32'h8400_0000, 32'h9400_0000,
        32'h8c00_0000, 32'ha000_0000, 32'ha400_0000, 32'hac00_0000, 32'h1000_0000,
        32'h1400_0000, 32'h1800_0000, 32'h1c00_0000, 32'h0400_0000, 32'h0401_0000,
        32'h0410_0000, 32'h0411_0000, 32'h0800_0000, 32'h0c00_0000
    };

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    id2_pkg::inst_fields_t instr;
    id2_pkg::fwd_sel_e     fwd_rs;
    id2_pkg::fwd_sel_e     fwd_rt;
    id2_pkg::bypass_t      bypass;
    id2_pkg::data_t        reg_r_data_1;
    id2_pkg::data_t        reg_r_data_2;
    id2_pkg::reg_addr_t    reg_r_addr_1;
    id2_pkg::reg_addr_t    reg_r_addr_2;
    logic                  out_valid;
    id2_pkg::id2_out_t     out;

    integer                seed;
    int                    burst_left;
    logic                  exp_valid;
    logic [31:0]           drv_word;
    id2_pkg::id2_out_t     last_out;
    id2_pkg::id2_out_t     exp_q[$];

    tb_clock_gen clk_gen0 (
        .clk (clk)
    );

    id2_stage dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .instr        (instr),
        .fwd_rs       (fwd_rs),
        .fwd_rt       (fwd_rt),
        .bypass       (bypass),
        .reg_r_data_1 (reg_r_data_1),
        .reg_r_data_2 (reg_r_data_2),
        .reg_r_addr_1 (reg_r_addr_1),
        .reg_r_addr_2 (reg_r_addr_2),
        .out_valid    (out_valid),
        .out          (out)
    );

    bind id2_stage id2_stage_props props0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out       (out)
    );

    function automatic logic [31:0] rand_below(input logic [31:0] n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // bits that a template leaves open, rs stays zero for constant shifts
    function automatic logic [31:0] free_bits(input logic [31:0] enc);
        case (enc[31:26])
            6'h00: return (enc[5:0] inside {6'h00, 6'h02, 6'h03}) ? 32'h001f_ffc0
                                                                  : 32'h03ff_ffc0;
            6'h01: return 32'h03e0_ffff;
            default: return 32'h03ff_ffff;
        endcase
    endfunction

    function automatic id2_pkg::inst_op_e model_op(input logic [31:0] w);
        logic [31:0]       key;
        id2_pkg::inst_op_e found;
        found = id2_pkg::OP_INVALID;
        case (w[31:26])
            6'h00: key = w & 32'hfc00_003f;
            6'h01: key = w & 32'hfc1f_0000;
            default: key = w & 32'hfc00_0000;
        endcase
        foreach (kept_enc[i]) begin
            if (kept_enc[i] == key) found = id2_pkg::inst_op_e'(6'(i + 1));
        end
        if (w[31:26] == 6'h00 && w[5:0] inside {6'h00, 6'h02, 6'h03} && w[25:21] != 5'd0) begin
            found = id2_pkg::OP_INVALID;
        end
        return found;
    endfunction

    function automatic logic in_range(input id2_pkg::inst_op_e op,
                                      input id2_pkg::inst_op_e lo,
                                      input id2_pkg::inst_op_e hi);
        return op >= lo && op <= hi;
    endfunction

    function automatic id2_pkg::exec_ctrl_t model_ctrl(input id2_pkg::inst_op_e op);
        id2_pkg::exec_ctrl_t c;
        logic                mem;
        c = '0;
        mem = in_range(op, id2_pkg::OP_LB, id2_pkg::OP_SW);
        case (op)
            id2_pkg::OP_ADD, id2_pkg::OP_ADDU,
            id2_pkg::OP_ADDI, id2_pkg::OP_ADDIU: c.alu_op = id2_pkg::ALU_ADD;
            id2_pkg::OP_SUB, id2_pkg::OP_SUBU:   c.alu_op = id2_pkg::ALU_SUB;
            id2_pkg::OP_SLT, id2_pkg::OP_SLTI:   c.alu_op = id2_pkg::ALU_SLT;
            id2_pkg::OP_SLTU, id2_pkg::OP_SLTIU: c.alu_op = id2_pkg::ALU_SLTU;
            id2_pkg::OP_AND, id2_pkg::OP_ANDI:   c.alu_op = id2_pkg::ALU_AND;
            id2_pkg::OP_OR, id2_pkg::OP_ORI:     c.alu_op = id2_pkg::ALU_OR;
            id2_pkg::OP_XOR, id2_pkg::OP_XORI:   c.alu_op = id2_pkg::ALU_XOR;
            id2_pkg::OP_NOR:                     c.alu_op = id2_pkg::ALU_NOR;
            id2_pkg::OP_SLL, id2_pkg::OP_SLLV:   c.alu_op = id2_pkg::ALU_SLL;
            id2_pkg::OP_SRL, id2_pkg::OP_SRLV:   c.alu_op = id2_pkg::ALU_SRL;
            id2_pkg::OP_SRA, id2_pkg::OP_SRAV:   c.alu_op = id2_pkg::ALU_SRA;
            id2_pkg::OP_LUI:                     c.alu_op = id2_pkg::ALU_LUI;
            id2_pkg::OP_MULT:                    c.alu_op = id2_pkg::ALU_MULT;
            id2_pkg::OP_MULTU:                   c.alu_op = id2_pkg::ALU_MULTU;
            id2_pkg::OP_DIV:                     c.alu_op = id2_pkg::ALU_DIV;
            id2_pkg::OP_DIVU:                    c.alu_op = id2_pkg::ALU_DIVU;
            id2_pkg::OP_MTHI:                    c.alu_op = id2_pkg::ALU_MTHI;
            id2_pkg::OP_MTLO:                    c.alu_op = id2_pkg::ALU_MTLO;
            default: c.alu_op = mem ? id2_pkg::ALU_ADD : id2_pkg::ALU_NONE;
        endcase
        if (in_range(op, id2_pkg::OP_SLL, id2_pkg::OP_SRAV)) c.src_a = id2_pkg::SRC_A_RT;
        if (in_range(op, id2_pkg::OP_ADD, id2_pkg::OP_NOR) ||
            in_range(op, id2_pkg::OP_MULT, id2_pkg::OP_DIVU)) c.src_b = id2_pkg::SRC_B_RT;
        if (in_range(op, id2_pkg::OP_ADDI, id2_pkg::OP_SW)) c.src_b = id2_pkg::SRC_B_IMM;
        if (in_range(op, id2_pkg::OP_SLLV, id2_pkg::OP_SRAV)) c.src_b = id2_pkg::SRC_B_RS;
        if (in_range(op, id2_pkg::OP_SLL, id2_pkg::OP_SRA)) c.src_b = id2_pkg::SRC_B_SA;
        if (op == id2_pkg::OP_MFHI) c.res_sel = id2_pkg::RES_HI;
        if (op == id2_pkg::OP_MFLO) c.res_sel = id2_pkg::RES_LO;
        if (op inside {id2_pkg::OP_JAL, id2_pkg::OP_JALR, id2_pkg::OP_BLTZAL,
                       id2_pkg::OP_BGEZAL}) c.res_sel = id2_pkg::RES_PC_8;
        // memory and branch selects follow the instruction order
        if (mem) c.ls_sel = id2_pkg::ls_sel_e'(4'(op - id2_pkg::OP_LB + 1));
        if (in_range(op, id2_pkg::OP_BEQ, id2_pkg::OP_BGEZAL)) begin
            c.branch_sel = id2_pkg::branch_sel_e'(4'(op - id2_pkg::OP_BEQ + 1));
        end
        if (in_range(op, id2_pkg::OP_MULT, id2_pkg::OP_DIVU)) c.w_hilo = 2'b11;
        if (op == id2_pkg::OP_MTHI) c.w_hilo = 2'b10;
        if (op == id2_pkg::OP_MTLO) c.w_hilo = 2'b01;
        c.wb_from_mem = in_range(op, id2_pkg::OP_LB, id2_pkg::OP_LW);
        c.sign_ext = mem || in_range(op, id2_pkg::OP_ADDI, id2_pkg::OP_SLTIU);
        return c;
    endfunction

    function automatic id2_pkg::exc_flags_t model_exc(input id2_pkg::inst_op_e op);
        id2_pkg::exc_flags_t e;
        e.syscall  = (op == id2_pkg::OP_SYSCALL);
        e.brk      = (op == id2_pkg::OP_BREAK);
        e.ri       = (op == id2_pkg::OP_INVALID);
        e.check_ov = op inside {id2_pkg::OP_ADD, id2_pkg::OP_SUB, id2_pkg::OP_ADDI};
        return e;
    endfunction

    // bypass results in select order, one past REG
    function automatic id2_pkg::data_t pick_fwd(input id2_pkg::fwd_sel_e sel,
                                                input id2_pkg::data_t    reg_data,
                                                input id2_pkg::bypass_t  bp);
        id2_pkg::data_t fields [6];
        fields = '{bp.exc_alu, bp.exp_alu, bp.memc_alu,
                   bp.memc_mem, bp.memp_alu, bp.memp_mem};
        if (sel == id2_pkg::FWD_REG) return reg_data;
        return fields[int'(sel) - 1];
    endfunction

    task automatic fail_run;
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_valid(input logic exp_v, input logic act);
        if (act !== exp_v) begin
            $display("Fail at %0t ns: out_valid expected %b, got %b", $time, exp_v, act);
            fail_run();
        end
    endtask

    task automatic check_ctrl(input id2_pkg::exec_ctrl_t exp_v, input id2_pkg::exec_ctrl_t act);
        if (act !== exp_v) begin
            $display("Fail at %0t ns: out.ctrl expected %h, got %h", $time, exp_v, act);
            fail_run();
        end
    endtask

    task automatic check_exc(input id2_pkg::exc_flags_t exp_v, input id2_pkg::exc_flags_t act);
        if (act !== exp_v) begin
            $display("Fail at %0t ns: out.exc expected %b, got %b", $time, exp_v, act);
            fail_run();
        end
    endtask

    task automatic check_data(input string name, input id2_pkg::data_t exp_v,
                              input id2_pkg::data_t act);
        if (act !== exp_v) begin
            $display("Fail at %0t ns: out.%s expected %h, got %h", $time, name, exp_v, act);
            fail_run();
        end
    endtask

    task automatic check_addr(input string name, input id2_pkg::reg_addr_t exp_v,
                              input id2_pkg::reg_addr_t act);
        if (act !== exp_v) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_v, act);
            fail_run();
        end
    endtask

    // out holds the last result between strobes
    task automatic check_outputs;
        check_valid(exp_valid, out_valid);
        if (exp_valid) last_out = exp_q.pop_front();
        check_ctrl(last_out.ctrl, out.ctrl);
        check_exc(last_out.exc, out.exc);
        check_data("rs_data", last_out.rs_data, out.rs_data);
        check_data("rt_data", last_out.rt_data, out.rt_data);
        check_data("ext_imm", last_out.ext_imm, out.ext_imm);
        check_data("sa", {27'd0, last_out.sa}, {27'd0, out.sa});
        // register file addresses follow the word still on instr
        check_addr("reg_r_addr_1", drv_word[25:21], reg_r_addr_1);
        check_addr("reg_r_addr_2", drv_word[20:16], reg_r_addr_2);
    endtask

    task automatic drive_inputs;
        logic [31:0]       word;
        logic [31:0]       enc;
        logic [5:0]        idx;
        id2_pkg::inst_op_e op;
        id2_pkg::id2_out_t e;
        if (burst_left == 0 && rand_below(4) == 0) burst_left = 1 + rand_below(8);
        in_valid = (burst_left != 0);
        if (burst_left != 0) burst_left = burst_left - 1;
        if (rand_below(8) == 0) begin
            word = $random(seed);
        end else begin
            idx = 6'(rand_below(n_kept));
            enc = kept_enc[idx];
            word = enc | ($random(seed) & free_bits(enc));
        end
        instr = word;
        drv_word = word;
        fwd_rs = id2_pkg::fwd_sel_e'(3'(rand_below(7)));
        fwd_rt = id2_pkg::fwd_sel_e'(3'(rand_below(7)));
        bypass = {$random(seed), $random(seed), $random(seed),
                  $random(seed), $random(seed), $random(seed)};
        reg_r_data_1 = $random(seed);
        reg_r_data_2 = $random(seed);
        exp_valid = in_valid;
        if (in_valid) begin
            op = model_op(word);
            e.ctrl = model_ctrl(op);
            e.exc = model_exc(op);
            e.rs_data = pick_fwd(fwd_rs, reg_r_data_1, bypass);
            e.rt_data = pick_fwd(fwd_rt, reg_r_data_2, bypass);
            e.ext_imm = e.ctrl.sign_ext ? {{16{word[15]}}, word[15:0]} : {16'd0, word[15:0]};
            e.sa = word[10:6];
            exp_q.push_back(e);
        end
    endtask

    initial begin
        #((n_tests + 20) * 100);
        $display("timeout: the test loop did not finish in the expected time");
        fail_run();
    end

    initial begin
        seed = 32'h847a;
        rst_n = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        fwd_rs = id2_pkg::FWD_REG;
        fwd_rt = id2_pkg::FWD_REG;
        bypass = '0;
        reg_r_data_1 = '0;
        reg_r_data_2 = '0;
        burst_left = 0;
        exp_valid = 1'b0;
        drv_word = '0;
        last_out = '0;
        #1 rst_n = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #5 check_valid(1'b0, out_valid);
        end
        #5 rst_n = 1'b1;
        // check 5 ns after the edge, drive 10 ns after it
        repeat (n_tests) begin
            @(posedge clk);
            #5 check_outputs();
            #5 drive_inputs();
        end
        @(posedge clk);
        #5 check_outputs();
        $display("No errors");
        $finish;
    end

endmodule

//--- sim/id2_stage_props.sv
`timescale 1ns/1ps

module id2_stage_props (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic              out_valid,
    input id2_pkg::id2_out_t out
);

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid is high while reset is asserted");

    a_strobe_follows: assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |=> out_valid)
        else $error("strobe was not followed by out_valid");

    a_no_extra_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) !in_valid |=> !out_valid)
        else $error("out_valid without a strobe in the cycle before");

    // reserved instructions carry no memory or hi/lo side effects
    a_ri_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out.exc.ri |->
            out.ctrl.ls_sel == id2_pkg::LS_NONE && out.ctrl.w_hilo == 2'b00)
        else $error("reserved instruction with memory or hi/lo controls");

    a_load_wb: assert property (@(posedge clk) disable iff (!rst_n)
        out.ctrl.wb_from_mem |-> out.ctrl.ls_sel inside {id2_pkg::LS_LB, id2_pkg::LS_LBU,
            id2_pkg::LS_LH, id2_pkg::LS_LHU, id2_pkg::LS_LW})
        else $error("write-back from memory without a load select");

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

//--- design/id2_stage.sv
`timescale 1ns/1ps

module id2_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  id2_pkg::inst_fields_t instr,
    input  id2_pkg::fwd_sel_e     fwd_rs,
    input  id2_pkg::fwd_sel_e     fwd_rt,
    input  id2_pkg::bypass_t      bypass,
    input  id2_pkg::data_t        reg_r_data_1,
    input  id2_pkg::data_t        reg_r_data_2,
    output id2_pkg::reg_addr_t    reg_r_addr_1,
    output id2_pkg::reg_addr_t    reg_r_addr_2,
    output logic                  out_valid,
    output id2_pkg::id2_out_t     out
);

    id2_pkg::inst_op_e   op;
    id2_pkg::exec_ctrl_t ctrl;
    id2_pkg::exc_flags_t exc;
    id2_pkg::data_t      rs_data;
    id2_pkg::data_t      rt_data;
    id2_pkg::data_t      ext_imm;
    id2_pkg::id2_out_t   out_next;

    // register file is read in the same cycle
    assign reg_r_addr_1 = instr.rs;
    assign reg_r_addr_2 = instr.rt;

    inst_classifier u_classifier (
        .instr (instr),
        .op    (op)
    );

    ctrl_decoder u_ctrl (
        .op   (op),
        .ctrl (ctrl),
        .exc  (exc)
    );

    operand_fetch u_operands (
        .fwd_rs       (fwd_rs),
        .fwd_rt       (fwd_rt),
        .bypass       (bypass),
        .reg_r_data_1 (reg_r_data_1),
        .reg_r_data_2 (reg_r_data_2),
        .imm          (instr.tail.imm),
        .sign_ext     (ctrl.sign_ext),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .ext_imm      (ext_imm)
    );

    always_comb begin
        out_next.ctrl    = ctrl;
        out_next.exc     = exc;
        out_next.rs_data = rs_data;
        out_next.rt_data = rt_data;
        out_next.ext_imm = ext_imm;
        out_next.sa      = instr.tail.r.sa;
    end

    // output register, holds its value between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out <= out_next;
            end
        end
    end

endmodule

//--- design/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
    input  id2_pkg::fwd_sel_e          fwd_rs,
    input  id2_pkg::fwd_sel_e          fwd_rt,
    input  id2_pkg::bypass_t           bypass,
    input  id2_pkg::data_t             reg_r_data_1,
    input  id2_pkg::data_t             reg_r_data_2,
    input  logic [id2_pkg::imm_w-1:0]  imm,
    input  logic                       sign_ext,
    output id2_pkg::data_t             rs_data,
    output id2_pkg::data_t             rt_data,
    output id2_pkg::data_t             ext_imm
);

    // seven-way bypass select, shared by both sources
    function automatic id2_pkg::data_t fwd_mux(
        input id2_pkg::fwd_sel_e sel,
        input id2_pkg::data_t    reg_data,
        input id2_pkg::bypass_t  bp
    );
        case (sel)
            id2_pkg::FWD_EXC_ALU:  return bp.exc_alu;
            id2_pkg::FWD_EXP_ALU:  return bp.exp_alu;
            id2_pkg::FWD_MEMC_ALU: return bp.memc_alu;
            id2_pkg::FWD_MEMC_MEM: return bp.memc_mem;
            id2_pkg::FWD_MEMP_ALU: return bp.memp_alu;
            id2_pkg::FWD_MEMP_MEM: return bp.memp_mem;
            default:               return reg_data;
        endcase
    endfunction

    assign rs_data = fwd_mux(fwd_rs, reg_r_data_1, bypass);
    assign rt_data = fwd_mux(fwd_rt, reg_r_data_2, bypass);

    // upper half from the sign bit or zero
    assign ext_imm = sign_ext ? {{(id2_pkg::xlen - id2_pkg::imm_w){imm[id2_pkg::imm_w-1]}}, imm}
                              : {{(id2_pkg::xlen - id2_pkg::imm_w){1'b0}}, imm};

endmodule

//--- design/ctrl_decoder.sv
`timescale 1ns/1ps

module ctrl_decoder (
    input  id2_pkg::inst_op_e  op,
    output id2_pkg::exec_ctrl_t ctrl,
    output id2_pkg::exc_flags_t exc
);

    always_comb begin
        // alu operation, memory ops compute their address with add
        case (op)
            id2_pkg::OP_ADD, id2_pkg::OP_ADDU, id2_pkg::OP_ADDI, id2_pkg::OP_ADDIU,
            id2_pkg::OP_LB, id2_pkg::OP_LBU, id2_pkg::OP_LH, id2_pkg::OP_LHU,
            id2_pkg::OP_LW, id2_pkg::OP_SB, id2_pkg::OP_SH,
            id2_pkg::OP_SW:                        ctrl.alu_op = id2_pkg::ALU_ADD;
            id2_pkg::OP_SUB, id2_pkg::OP_SUBU:     ctrl.alu_op = id2_pkg::ALU_SUB;
            id2_pkg::OP_SLT, id2_pkg::OP_SLTI:     ctrl.alu_op = id2_pkg::ALU_SLT;
            id2_pkg::OP_SLTU, id2_pkg::OP_SLTIU:   ctrl.alu_op = id2_pkg::ALU_SLTU;
            id2_pkg::OP_AND, id2_pkg::OP_ANDI:     ctrl.alu_op = id2_pkg::ALU_AND;
            id2_pkg::OP_OR, id2_pkg::OP_ORI:       ctrl.alu_op = id2_pkg::ALU_OR;
            id2_pkg::OP_XOR, id2_pkg::OP_XORI:     ctrl.alu_op = id2_pkg::ALU_XOR;
            id2_pkg::OP_NOR:                       ctrl.alu_op = id2_pkg::ALU_NOR;
            id2_pkg::OP_SLL, id2_pkg::OP_SLLV:     ctrl.alu_op = id2_pkg::ALU_SLL;
            id2_pkg::OP_SRL, id2_pkg::OP_SRLV:     ctrl.alu_op = id2_pkg::ALU_SRL;
            id2_pkg::OP_SRA, id2_pkg::OP_SRAV:     ctrl.alu_op = id2_pkg::ALU_SRA;
            id2_pkg::OP_LUI:                       ctrl.alu_op = id2_pkg::ALU_LUI;
            id2_pkg::OP_MULT:                      ctrl.alu_op = id2_pkg::ALU_MULT;
            id2_pkg::OP_MULTU:                     ctrl.alu_op = id2_pkg::ALU_MULTU;
            id2_pkg::OP_DIV:                       ctrl.alu_op = id2_pkg::ALU_DIV;
            id2_pkg::OP_DIVU:                      ctrl.alu_op = id2_pkg::ALU_DIVU;
            id2_pkg::OP_MTHI:                      ctrl.alu_op = id2_pkg::ALU_MTHI;
            id2_pkg::OP_MTLO:                      ctrl.alu_op = id2_pkg::ALU_MTLO;
            default:                               ctrl.alu_op = id2_pkg::ALU_NONE;
        endcase

        // shifts take their data from rt
        if (op inside {id2_pkg::OP_SLL, id2_pkg::OP_SRL, id2_pkg::OP_SRA,
                       id2_pkg::OP_SLLV, id2_pkg::OP_SRLV, id2_pkg::OP_SRAV}) begin
            ctrl.src_a = id2_pkg::SRC_A_RT;
        end else begin
            ctrl.src_a = id2_pkg::SRC_A_RS;
        end

        case (op)
            id2_pkg::OP_ADD, id2_pkg::OP_ADDU, id2_pkg::OP_SUB, id2_pkg::OP_SUBU,
            id2_pkg::OP_SLT, id2_pkg::OP_SLTU, id2_pkg::OP_AND, id2_pkg::OP_OR,
            id2_pkg::OP_XOR, id2_pkg::OP_NOR, id2_pkg::OP_MULT, id2_pkg::OP_MULTU,
            id2_pkg::OP_DIV, id2_pkg::OP_DIVU:     ctrl.src_b = id2_pkg::SRC_B_RT;
            id2_pkg::OP_ADDI, id2_pkg::OP_ADDIU, id2_pkg::OP_SLTI, id2_pkg::OP_SLTIU,
            id2_pkg::OP_ANDI, id2_pkg::OP_ORI, id2_pkg::OP_XORI, id2_pkg::OP_LUI,
            id2_pkg::OP_LB, id2_pkg::OP_LBU, id2_pkg::OP_LH, id2_pkg::OP_LHU,
            id2_pkg::OP_LW, id2_pkg::OP_SB, id2_pkg::OP_SH,
            id2_pkg::OP_SW:                        ctrl.src_b = id2_pkg::SRC_B_IMM;
            id2_pkg::OP_SLLV, id2_pkg::OP_SRLV,
            id2_pkg::OP_SRAV:                      ctrl.src_b = id2_pkg::SRC_B_RS;
            id2_pkg::OP_SLL, id2_pkg::OP_SRL,
            id2_pkg::OP_SRA:                       ctrl.src_b = id2_pkg::SRC_B_SA;
            default:                               ctrl.src_b = id2_pkg::SRC_B_NONE;
        endcase

        // link instructions write pc + 8
        case (op)
            id2_pkg::OP_MFHI:                      ctrl.res_sel = id2_pkg::RES_HI;
            id2_pkg::OP_MFLO:                      ctrl.res_sel = id2_pkg::RES_LO;
            id2_pkg::OP_JAL, id2_pkg::OP_JALR,
            id2_pkg::OP_BLTZAL, id2_pkg::OP_BGEZAL: ctrl.res_sel = id2_pkg::RES_PC_8;
            default:                               ctrl.res_sel = id2_pkg::RES_ALU;
        endcase

        case (op)
            id2_pkg::OP_LB:  ctrl.ls_sel = id2_pkg::LS_LB;
            id2_pkg::OP_LBU: ctrl.ls_sel = id2_pkg::LS_LBU;
            id2_pkg::OP_LH:  ctrl.ls_sel = id2_pkg::LS_LH;
            id2_pkg::OP_LHU: ctrl.ls_sel = id2_pkg::LS_LHU;
            id2_pkg::OP_LW:  ctrl.ls_sel = id2_pkg::LS_LW;
            id2_pkg::OP_SB:  ctrl.ls_sel = id2_pkg::LS_SB;
            id2_pkg::OP_SH:  ctrl.ls_sel = id2_pkg::LS_SH;
            id2_pkg::OP_SW:  ctrl.ls_sel = id2_pkg::LS_SW;
            default:         ctrl.ls_sel = id2_pkg::LS_NONE;
        endcase

        case (op)
            id2_pkg::OP_BEQ:    ctrl.branch_sel = id2_pkg::BR_BEQ;
            id2_pkg::OP_BNE:    ctrl.branch_sel = id2_pkg::BR_BNE;
            id2_pkg::OP_BLEZ:   ctrl.branch_sel = id2_pkg::BR_BLEZ;
            id2_pkg::OP_BGTZ:   ctrl.branch_sel = id2_pkg::BR_BGTZ;
            id2_pkg::OP_BLTZ:   ctrl.branch_sel = id2_pkg::BR_BLTZ;
            id2_pkg::OP_BGEZ:   ctrl.branch_sel = id2_pkg::BR_BGEZ;
            id2_pkg::OP_BLTZAL: ctrl.branch_sel = id2_pkg::BR_BLTZAL;
            id2_pkg::OP_BGEZAL: ctrl.branch_sel = id2_pkg::BR_BGEZAL;
            default:            ctrl.branch_sel = id2_pkg::BR_NONE;
        endcase

        // hi/lo write enables
        case (op)
            id2_pkg::OP_MULT, id2_pkg::OP_MULTU,
            id2_pkg::OP_DIV, id2_pkg::OP_DIVU: ctrl.w_hilo = 2'b11;
            id2_pkg::OP_MTHI:                  ctrl.w_hilo = 2'b10;
            id2_pkg::OP_MTLO:                  ctrl.w_hilo = 2'b01;
            default:                           ctrl.w_hilo = 2'b00;
        endcase

        ctrl.wb_from_mem = op inside {id2_pkg::OP_LB, id2_pkg::OP_LBU, id2_pkg::OP_LH,
                                      id2_pkg::OP_LHU, id2_pkg::OP_LW};
        ctrl.sign_ext = op inside {id2_pkg::OP_ADDI, id2_pkg::OP_ADDIU, id2_pkg::OP_SLTI,
                                   id2_pkg::OP_SLTIU, id2_pkg::OP_LB, id2_pkg::OP_LBU,
                                   id2_pkg::OP_LH, id2_pkg::OP_LHU, id2_pkg::OP_LW,
                                   id2_pkg::OP_SB, id2_pkg::OP_SH, id2_pkg::OP_SW};

        exc.syscall  = (op == id2_pkg::OP_SYSCALL);
        exc.brk      = (op == id2_pkg::OP_BREAK);
        exc.ri       = (op == id2_pkg::OP_INVALID);
        // only the trapping adds and sub
        exc.check_ov = op inside {id2_pkg::OP_ADD, id2_pkg::OP_SUB, id2_pkg::OP_ADDI};
    end

endmodule

//--- design/inst_classifier.sv
`timescale 1ns/1ps

module inst_classifier (
    input  id2_pkg::inst_fields_t instr,
    output id2_pkg::inst_op_e     op
);

    logic [5:0] funct;

    assign funct = instr.tail.r.funct;

    always_comb begin
        op = id2_pkg::OP_INVALID;
        case (instr.op)
            // SPECIAL, resolved by funct
            6'h00: begin
                case (funct)
                    6'h00: op = id2_pkg::OP_SLL;
                    6'h02: op = id2_pkg::OP_SRL;
                    6'h03: op = id2_pkg::OP_SRA;
                    6'h04: op = id2_pkg::OP_SLLV;
                    6'h06: op = id2_pkg::OP_SRLV;
                    6'h07: op = id2_pkg::OP_SRAV;
                    6'h08: op = id2_pkg::OP_JR;
                    6'h09: op = id2_pkg::OP_JALR;
                    6'h0c: op = id2_pkg::OP_SYSCALL;
                    6'h0d: op = id2_pkg::OP_BREAK;
                    6'h10: op = id2_pkg::OP_MFHI;
                    6'h11: op = id2_pkg::OP_MTHI;
                    6'h12: op = id2_pkg::OP_MFLO;
                    6'h13: op = id2_pkg::OP_MTLO;
                    6'h18: op = id2_pkg::OP_MULT;
                    6'h19: op = id2_pkg::OP_MULTU;
                    6'h1a: op = id2_pkg::OP_DIV;
                    6'h1b: op = id2_pkg::OP_DIVU;
                    6'h20: op = id2_pkg::OP_ADD;
                    6'h21: op = id2_pkg::OP_ADDU;
                    6'h22: op = id2_pkg::OP_SUB;
                    6'h23: op = id2_pkg::OP_SUBU;
                    6'h24: op = id2_pkg::OP_AND;
                    6'h25: op = id2_pkg::OP_OR;
                    6'h26: op = id2_pkg::OP_XOR;
                    6'h27: op = id2_pkg::OP_NOR;
                    6'h2a: op = id2_pkg::OP_SLT;
                    6'h2b: op = id2_pkg::OP_SLTU;
                    default: op = id2_pkg::OP_INVALID;
                endcase
                // constant shifts must leave rs zero, nop passes as sll
                if (funct inside {6'h00, 6'h02, 6'h03} && instr.rs != '0) begin
                    op = id2_pkg::OP_INVALID;
                end
            end
            // REGIMM, resolved by rt
            6'h01: begin
                case (instr.rt)
                    5'h00: op = id2_pkg::OP_BLTZ;
                    5'h01: op = id2_pkg::OP_BGEZ;
                    5'h10: op = id2_pkg::OP_BLTZAL;
                    5'h11: op = id2_pkg::OP_BGEZAL;
                    default: op = id2_pkg::OP_INVALID;
                endcase
            end
            6'h02: op = id2_pkg::OP_J;
            6'h03: op = id2_pkg::OP_JAL;
            6'h04: op = id2_pkg::OP_BEQ;
            6'h05: op = id2_pkg::OP_BNE;
            6'h06: op = id2_pkg::OP_BLEZ;
            6'h07: op = id2_pkg::OP_BGTZ;
            6'h08: op = id2_pkg::OP_ADDI;
            6'h09: op = id2_pkg::OP_ADDIU;
            6'h0a: op = id2_pkg::OP_SLTI;
            6'h0b: op = id2_pkg::OP_SLTIU;
            6'h0c: op = id2_pkg::OP_ANDI;
            6'h0d: op = id2_pkg::OP_ORI;
            6'h0e: op = id2_pkg::OP_XORI;
            6'h0f: op = id2_pkg::OP_LUI;
            6'h20: op = id2_pkg::OP_LB;
            6'h21: op = id2_pkg::OP_LH;
            6'h23: op = id2_pkg::OP_LW;
            6'h24: op = id2_pkg::OP_LBU;
            6'h25: op = id2_pkg::OP_LHU;
            6'h28: op = id2_pkg::OP_SB;
            6'h29: op = id2_pkg::OP_SH;
            6'h2b: op = id2_pkg::OP_SW;
            default: op = id2_pkg::OP_INVALID;
        endcase
    end

endmodule

//--- design/id2_pkg.sv
package id2_pkg;

    // fixed MIPS32 datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 16;

    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [xlen-1:0]       data_t;

    // one value per kept instruction
    typedef enum logic [5:0] {
        OP_INVALID,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_SLLV, OP_SRLV, OP_SRAV,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_JR, OP_JALR, OP_SYSCALL, OP_BREAK,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_J, OP_JAL
    } inst_op_e;

    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
        ALU_MTHI, ALU_MTLO
    } alu_op_e;

    typedef enum logic {
        SRC_A_RS,
        SRC_A_RT
    } src_a_e;

    typedef enum logic [2:0] {
        SRC_B_NONE, SRC_B_RT, SRC_B_IMM, SRC_B_RS, SRC_B_SA
    } src_b_e;

    typedef enum logic [1:0] {
        RES_ALU, RES_HI, RES_LO, RES_PC_8
    } res_sel_e;

    typedef enum logic [3:0] {
        LS_NONE, LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW, LS_SB, LS_SH, LS_SW
    } ls_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ,
        BR_BLTZ, BR_BGEZ, BR_BLTZAL, BR_BGEZAL
    } branch_sel_e;

    // forwarding source, REG means no bypass
    typedef enum logic [2:0] {
        FWD_REG, FWD_EXC_ALU, FWD_EXP_ALU, FWD_MEMC_ALU,
        FWD_MEMC_MEM, FWD_MEMP_ALU, FWD_MEMP_MEM
    } fwd_sel_e;

    // rd/sa/funct and imm share the low half of the word
    typedef struct packed {
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_tail_t;

    typedef union packed {
        r_tail_t           r;
        logic [imm_w-1:0]  imm;
    } inst_tail_t;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        inst_tail_t tail;
    } inst_fields_t;

    typedef struct packed {
        alu_op_e     alu_op;
        src_a_e      src_a;
        src_b_e      src_b;
        res_sel_e    res_sel;
        ls_sel_e     ls_sel;
        branch_sel_e branch_sel;
        logic [1:0]  w_hilo;      // hi, lo
        logic        wb_from_mem;
        logic        sign_ext;
    } exec_ctrl_t;

    typedef struct packed {
        logic syscall;
        logic brk;
        logic ri;
        logic check_ov;
    } exc_flags_t;

    typedef struct packed {
        data_t exc_alu;
        data_t exp_alu;
        data_t memc_alu;
        data_t memc_mem;
        data_t memp_alu;
        data_t memp_mem;
    } bypass_t;

    typedef struct packed {
        exec_ctrl_t ctrl;
        exc_flags_t exc;
        data_t      rs_data;
        data_t      rt_data;
        data_t      ext_imm;
        logic [4:0] sa;
    } id2_out_t;

endpackage
